// File: src/l2d_params.svh
// size macros for the l2 data bank: sets, ways, ecc words, fuse registers
`ifndef L2D_PARAMS_SVH
`define L2D_PARAMS_SVH

//////////////////////////////////////////////////////////////////////
// array geometry
//////////////////////////////////////////////////////////////////////
`define L2D_SET_BITS   10    // 1024 sets per way
`define L2D_WAYS       2     // way_sel is one bit per way
`define L2D_WORDS      4     // ecc words per line
`define L2D_WORD_BITS  39    // 32 data + 7 check bits

// full line, word 0 in the low bits
`define L2D_LINE_BITS  (`L2D_WORDS * `L2D_WORD_BITS)

//////////////////////////////////////////////////////////////////////
// redundancy fuse chain
//////////////////////////////////////////////////////////////////////
`define L2D_FUSE_REGS  6     // row/column repair registers
`define L2D_FUSE_BITS  9     // bits per repair register

`endif

// File: src/l2d_pkg.sv
// types shared by the l2 data bank: line, request and fuse command structs
package l2d_pkg;

`include "l2d_params.svh"

   // register id wide enough for every repair register
   localparam int FUSE_ID_BITS = $clog2(`L2D_FUSE_REGS);

   //////////////////////////////////////////////////////////////////////
   // data path
   //////////////////////////////////////////////////////////////////////

   // one cache line, four ecc words, word 0 at [38:0]
   typedef logic [`L2D_LINE_BITS-1:0] l2d_line_t;

   // one request as presented at the bank port
   typedef struct packed {
      logic                      wr;       // 1 = store, 0 = load
      logic [`L2D_WAYS-1:0]      way_sel;  // one bit per way
      logic [`L2D_SET_BITS-1:0]  set;      // set index
      logic [`L2D_WORDS-1:0]     word_en;  // per word store enable
      l2d_line_t                 wdata;    // store data, already ecc encoded
   } l2d_req_t;

   //////////////////////////////////////////////////////////////////////
   // fuse side band
   //////////////////////////////////////////////////////////////////////

   typedef struct packed {
      logic                      wren;     // shift one register, wins over rden
      logic                      rden;     // shift the whole chain
      logic [FUSE_ID_BITS-1:0]   rid;      // register picked for write
      logic                      wdata;    // serial write bit
   } l2d_fuse_cmd_t;

endpackage

// File: src/l2d_req_stage.sv
// request capture stage with two-cycle occupancy and the ready logic
`timescale 1ns/1ps

module l2d_req_stage (
   input  logic               rclk,
   input  logic               arst_l,
   input  l2d_pkg::l2d_req_t  req,
   input  logic               req_valid,
   output logic               req_ready,
   output l2d_pkg::l2d_req_t  acc_req,
   output logic               acc_valid
);

   import l2d_pkg::*;

   logic accept;   // handshake this edge

   //////////////////////////////////////////////////////////////////////
   // occupancy
   //////////////////////////////////////////////////////////////////////

   // column access takes two cycles, so the cycle right after an accept
   // is blocked; acc_valid high marks exactly that cycle
   assign req_ready = ~acc_valid;
   assign accept    = req_valid & req_ready;

   always_ff @(posedge rclk) begin
      if (!arst_l) begin
         acc_valid <= 1'b0;
      end else begin
         acc_valid <= accept;   // one cycle pulse per request
      end
   end

   // payload flop, only loads on a handshake
   always_ff @(posedge rclk) begin
      if (accept) begin
         acc_req <= req;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // checks
   //////////////////////////////////////////////////////////////////////

   // a request with no way picked would access nothing
   a_way_nonzero : assert property (
      @(posedge rclk) disable iff (!arst_l)
      accept |-> (|req.way_sel)
   ) else $error("request accepted with way_sel zero");

   // loads read one way only, stores may hit several
   a_rd_onehot : assert property (
      @(posedge rclk) disable iff (!arst_l)
      (accept && !req.wr) |-> $onehot(req.way_sel)
   ) else $error("read accepted with way_sel not one-hot");

   // request must stay up until taken
   a_valid_hold : assert property (
      @(posedge rclk) disable iff (!arst_l)
      (req_valid && !req_ready) |=> req_valid
   ) else $error("req_valid dropped while stalled");

endmodule

// File: src/l2d_array_stage.sv
// two-way data array with word-enable merge, write disable and read select
`timescale 1ns/1ps

`include "l2d_params.svh"

module l2d_array_stage (
   input  logic                rclk,
   input  logic                arst_l,
   input  l2d_pkg::l2d_req_t   acc_req,
   input  logic                acc_valid,
   input  logic                write_disable,
   output l2d_pkg::l2d_line_t  rd_line,
   output logic                rd_line_valid
);

   import l2d_pkg::*;

   localparam int SETS = 2 ** `L2D_SET_BITS;
   localparam int WB   = `L2D_WORD_BITS;

   l2d_line_t way_line [`L2D_WAYS];   // stored line at acc set, per way
   logic      wr_commit;              // store allowed this cycle
   logic      rd_access;              // load this cycle

   assign wr_commit = acc_valid & acc_req.wr & ~write_disable;   // wd kills all ways
   assign rd_access = acc_valid & ~acc_req.wr;

   //////////////////////////////////////////////////////////////////////
   // way arrays
   //////////////////////////////////////////////////////////////////////

   for (genvar w = 0; w < `L2D_WAYS; w++) begin : g_way
      l2d_line_t mem [SETS];   // one line per set
      l2d_line_t merged;       // store data merged onto this way's old line

      assign way_line[w] = mem[acc_req.set];

      // new word where enabled, old word kept otherwise
      always_comb begin
         for (int d = 0; d < `L2D_WORDS; d++) begin
            merged[d*WB +: WB] = acc_req.word_en[d] ? acc_req.wdata[d*WB +: WB]
                                                    : way_line[w][d*WB +: WB];
         end
      end

      always_ff @(posedge rclk) begin
         if (wr_commit && acc_req.way_sel[w]) begin
            mem[acc_req.set] <= merged;   // every selected way takes the line
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // read select
   //////////////////////////////////////////////////////////////////////

   // way 0 wins if its bit is set, way 1 otherwise
   always_ff @(posedge rclk) begin
      if (rd_access) begin
         rd_line <= acc_req.way_sel[0] ? way_line[0] : way_line[1];
      end
   end

   always_ff @(posedge rclk) begin
      if (!arst_l) begin
         rd_line_valid <= 1'b0;
      end else begin
         rd_line_valid <= rd_access;   // stores give no response
      end
   end

   // request stage must block the cycle after each access
   a_no_b2b_access : assert property (
      @(posedge rclk) disable iff (!arst_l)
      acc_valid |=> !acc_valid
   ) else $error("array accessed on two consecutive cycles");

endmodule

// File: src/l2d_rd_return.sv
// read hold stage driving the wired-or read bus chained through the banks
`timescale 1ns/1ps

module l2d_rd_return (
   input  logic                rclk,
   input  logic                arst_l,
   input  l2d_pkg::l2d_line_t  rd_line,
   input  logic                rd_line_valid,
   input  l2d_pkg::l2d_line_t  rd_chain_in,
   output l2d_pkg::l2d_line_t  rd_chain_out,
   output logic                rsp_valid
);

   import l2d_pkg::*;

   localparam logic [1:0] HOLD_CYC = 2'd2;   // cycles a line stays on the bus

   l2d_line_t  held_line;   // line being returned
   logic [1:0] hold_cnt;    // cycles left, 0 = idle

   always_ff @(posedge rclk) begin
      if (!arst_l) begin
         hold_cnt <= '0;
      end else if (rd_line_valid) begin
         hold_cnt <= HOLD_CYC;
      end else if (hold_cnt != '0) begin
         hold_cnt <= hold_cnt - 2'd1;
      end
   end

   always_ff @(posedge rclk) begin
      if (rd_line_valid) begin
         held_line <= rd_line;
      end
   end

   assign rsp_valid = (hold_cnt != '0);

   // idle bank adds zeros, upstream data passes straight through
   assign rd_chain_out = rsp_valid ? (held_line | rd_chain_in) : rd_chain_in;

   // a new line in the first hold cycle would cut a response short
   a_no_overlap : assert property (
      @(posedge rclk) disable iff (!arst_l)
      rd_line_valid |-> (hold_cnt != HOLD_CYC)
   ) else $error("read line arrived during first hold cycle");

endmodule

// File: src/l2d_fuse_chain.sv
// six redundancy registers with per-register serial write and chain shift-out
`timescale 1ns/1ps

`include "l2d_params.svh"

module l2d_fuse_chain (
   input  logic                   rclk,
   input  logic                   arst_l,
   input  l2d_pkg::l2d_fuse_cmd_t fuse_cmd,
   input  logic                   fuse_read_in,
   output logic                   fuse_out
);

   import l2d_pkg::*;

   localparam int NREG = `L2D_FUSE_REGS;
   localparam int NBIT = `L2D_FUSE_BITS;

   logic [NBIT-1:0] red_reg [NREG];   // repair registers, 0 at chain input
   logic            rid_ok;           // rid names a real register

   // ids 6 and 7 fall off the end
   assign rid_ok = (int'(fuse_cmd.rid) < NREG);

   //////////////////////////////////////////////////////////////////////
   // shift control
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge rclk) begin
      if (!arst_l) begin
         for (int r = 0; r < NREG; r++) begin
            red_reg[r] <= '0;
         end
      end else if (fuse_cmd.wren) begin
         // only the named register shifts left in write mode
         if (rid_ok) begin
            red_reg[fuse_cmd.rid] <= {red_reg[fuse_cmd.rid][NBIT-2:0], fuse_cmd.wdata};
         end
      end else if (fuse_cmd.rden) begin
         // read mode shifts all registers as one 54 bit chain
         red_reg[0] <= {red_reg[0][NBIT-2:0], fuse_read_in};
         for (int r = 1; r < NREG; r++) begin
            red_reg[r] <= {red_reg[r][NBIT-2:0], red_reg[r-1][NBIT-1]};   // msb of prev
         end
      end
   end

   // chain tail
   assign fuse_out = red_reg[NREG-1][NBIT-1];

endmodule

// File: src/l2d_bank.sv
// l2 data bank top: request stage, array stage, read return and fuse chain
`timescale 1ns/1ps

module l2d_bank (
   input  logic                   rclk,
   input  logic                   arst_l,
   // request port
   input  l2d_pkg::l2d_req_t      req,
   input  logic                   req_valid,
   output logic                   req_ready,
   // test
   input  logic                   write_disable,
   // chained read bus
   input  l2d_pkg::l2d_line_t     rd_chain_in,
   output l2d_pkg::l2d_line_t     rd_chain_out,
   output logic                   rsp_valid,
   // redundancy fuses
   input  l2d_pkg::l2d_fuse_cmd_t fuse_cmd,
   input  logic                   fuse_read_in,
   output logic                   fuse_out
);

   import l2d_pkg::*;

   l2d_req_t  acc_req;         // request in its access cycle
   logic      acc_valid;
   l2d_line_t rd_line;         // array read data
   logic      rd_line_valid;

   //////////////////////////////////////////////////////////////////////
   // pipeline
   //////////////////////////////////////////////////////////////////////

   l2d_req_stage u_req_stage (
      .rclk      (rclk),
      .arst_l    (arst_l),
      .req       (req),
      .req_valid (req_valid),
      .req_ready (req_ready),
      .acc_req   (acc_req),
      .acc_valid (acc_valid)
   );

   l2d_array_stage u_array_stage (
      .rclk          (rclk),
      .arst_l        (arst_l),
      .acc_req       (acc_req),
      .acc_valid     (acc_valid),
      .write_disable (write_disable),
      .rd_line       (rd_line),
      .rd_line_valid (rd_line_valid)
   );

   l2d_rd_return u_rd_return (
      .rclk          (rclk),
      .arst_l        (arst_l),
      .rd_line       (rd_line),
      .rd_line_valid (rd_line_valid),
      .rd_chain_in   (rd_chain_in),
      .rd_chain_out  (rd_chain_out),
      .rsp_valid     (rsp_valid)
   );

   // side band, not tied to the request pipe
   l2d_fuse_chain u_fuse_chain (
      .rclk         (rclk),
      .arst_l       (arst_l),
      .fuse_cmd     (fuse_cmd),
      .fuse_read_in (fuse_read_in),
      .fuse_out     (fuse_out)
   );

endmodule

// File: testbench/tb_l2d_bank.sv
// testbench for the l2 data bank: clock, reset, watchdog, reference model and directed tests
`timescale 1ns/1ps

`include "l2d_params.svh"

module tb_l2d_bank;

   import l2d_pkg::*;

   localparam int NUM_TESTS = 6;
   localparam int CYCLE_NS  = 100;
   localparam int WB        = `L2D_WORD_BITS;
   localparam int NREG      = `L2D_FUSE_REGS;
   localparam int NBIT      = `L2D_FUSE_BITS;
   localparam logic [8:0] FUSE_PAT [6] = '{9'h155, 9'h0f3, 9'h1c8, 9'h02d, 9'h1ff, 9'h101};

   logic rclk, arst_l, req_valid, req_ready, write_disable, rsp_valid;
   logic fuse_read_in, fuse_out;
   l2d_req_t      req;
   l2d_line_t     rd_chain_in, rd_chain_out;
   l2d_fuse_cmd_t fuse_cmd;

   int errors, test_errors, tests_run, tests_failed;   // bookkeeping
   l2d_line_t model_way0 [int];   // reference lines by set
   l2d_line_t model_way1 [int];

   l2d_bank DUT (
      .rclk(rclk), .arst_l(arst_l), .req(req), .req_valid(req_valid),
      .req_ready(req_ready), .write_disable(write_disable), .rd_chain_in(rd_chain_in),
      .rd_chain_out(rd_chain_out), .rsp_valid(rsp_valid), .fuse_cmd(fuse_cmd),
      .fuse_read_in(fuse_read_in), .fuse_out(fuse_out)
   );

   initial rclk = 1'b0;
   always #(CYCLE_NS / 2) rclk = ~rclk;   // 100 ns period

   //////////////////////////////////////////////////////////////////////
   // reporting and reference model
   //////////////////////////////////////////////////////////////////////

   task automatic flag_error(input string msg);
      $display("CHECK FAILED at %0t: %s", $time, msg);
      errors++;
   endtask

   task automatic note_failure(input string msg);
      $display("at %0t the bank failed: %s", $time, msg);   // protocol problem, no value
      errors++;
   endtask

   function automatic l2d_line_t rand_line();
      l2d_line_t l;
      l = '0;
      for (int i = 0; i < 5; i++) begin
         l = {l[`L2D_LINE_BITS-33:0], $urandom()};   // five 32 bit draws, top bits drop
      end
      return l;
   endfunction

   function automatic l2d_line_t model_get(input int way, input int set_idx);
      if (way == 0) return model_way0.exists(set_idx) ? model_way0[set_idx] : '0;
      return model_way1.exists(set_idx) ? model_way1[set_idx] : '0;
   endfunction

   // enabled 39 bit words replaced, the rest kept
   function automatic l2d_line_t merge_words(input l2d_line_t old_l, input l2d_line_t new_l,
                                             input logic [3:0] wen);
      l2d_line_t res;
      res = old_l;
      for (int d = 0; d < `L2D_WORDS; d++) begin
         if (wen[d]) res[d*WB +: WB] = new_l[d*WB +: WB];
      end
      return res;
   endfunction

   //////////////////////////////////////////////////////////////////////
   // request drivers, called and returning on a falling edge
   //////////////////////////////////////////////////////////////////////

   task automatic wait_ready();
      int n;
      n = 0;
      while (!req_ready && n < 8) begin   // valid stays up meanwhile
         @(negedge rclk);
         n++;
      end
      if (!req_ready) note_failure("req_ready stuck low, request never accepted");
   endtask

   task automatic send_req(input logic wr, input logic [1:0] way, input logic [9:0] set_idx,
                           input logic [3:0] wen, input l2d_line_t data);
      req = '{wr: wr, way_sel: way, set: set_idx, word_en: wen, wdata: data};
      req_valid = 1'b1;
      wait_ready();
      @(negedge rclk);   // handshake edge passed
      req_valid = 1'b0;
      if (req_ready) flag_error("req_ready high in the cycle after acceptance");
   endtask

   task automatic write_line(input logic [1:0] way, input logic [9:0] set_idx,
                             input logic [3:0] wen, input l2d_line_t data);
      send_req(1'b1, way, set_idx, wen, data);
      for (int w = 0; w < 2; w++) begin
         if (way[w] && !write_disable) begin
            if (w == 0) model_way0[set_idx] = merge_words(model_get(0, set_idx), data, wen);
            else model_way1[set_idx] = merge_words(model_get(1, set_idx), data, wen);
         end
      end
   endtask

   // one read, two-cycle response starting two edges after acceptance
   task automatic read_check(input int way, input logic [9:0] set_idx, input l2d_line_t chain);
      l2d_line_t exp;
      int        lat;
      exp = model_get(way, set_idx);
      rd_chain_in = chain;
      send_req(1'b0, (way == 0) ? 2'b01 : 2'b10, set_idx, 4'h0, '0);
      lat = 0;
      while (!rsp_valid && lat < 8) begin
         if (rd_chain_out !== chain) flag_error("idle rd_chain_out is not rd_chain_in");
         @(negedge rclk);
         lat++;
      end
      if (!rsp_valid) begin
         note_failure("rsp_valid never rose for a read");
      end else begin
         if (lat != 2) flag_error($sformatf("rsp_valid rose %0d edges after accept", lat));
         for (int c = 0; c < 2; c++) begin
            if (!rsp_valid) flag_error("rsp_valid dropped inside the two-cycle hold");
            if (rd_chain_out !== (exp | chain)) begin
               flag_error($sformatf("way %0d set %0d read %h, expected %h", way, set_idx,
                                    rd_chain_out, exp | chain));
            end
            @(negedge rclk);
         end
         if (rsp_valid) flag_error("rsp_valid held past two cycles");
         if (rd_chain_out !== chain) flag_error("rd_chain_out not back to rd_chain_in");
      end
      rd_chain_in = '0;
   endtask

   task automatic finish_test(input string name);
      tests_run++;
      if (errors == test_errors) begin
         $display("test %s: ok", name);
      end else begin
         tests_failed++;
         $display("test %s: %0d failed checks", name, errors - test_errors);
      end
      test_errors = errors;
   endtask

   //////////////////////////////////////////////////////////////////////
   // directed tests
   //////////////////////////////////////////////////////////////////////

   task automatic test_full_write();
      logic [9:0] s;
      for (int i = 0; i < 4; i++) begin
         s = 10'($urandom());
         write_line(2'b01, s, 4'hf, rand_line());   // both ways known first
         write_line(2'b10, s, 4'hf, rand_line());
         write_line((i % 2 == 0) ? 2'b01 : 2'b10, s, 4'hf, rand_line());
         read_check(i % 2, s, '0);
         read_check(1 - i % 2, s, '0);   // other way untouched
      end
      finish_test("full line write");
   endtask

   task automatic test_partial_write();
      logic [9:0] s;
      for (int i = 0; i < 4; i++) begin
         s = 10'($urandom());
         write_line((i < 2) ? 2'b01 : 2'b10, s, 4'hf, rand_line());   // base line
         write_line((i < 2) ? 2'b01 : 2'b10, s, 4'($urandom()), rand_line());
         write_line((i < 2) ? 2'b01 : 2'b10, s, 4'($urandom()), rand_line());
         read_check(i / 2, s, '0);
      end
      finish_test("partial write");
   endtask

   task automatic test_occupancy();
      logic [9:0] sa, sb;
      l2d_line_t  exp;
      sa = 10'($urandom());
      sb = sa ^ 10'h2a5;
      write_line(2'b01, sa, 4'hf, rand_line());
      write_line(2'b10, sb, 4'hf, rand_line());
      req = '{wr: 1'b0, way_sel: 2'b01, set: sa, word_en: 4'h0, wdata: '0};
      req_valid = 1'b1;
      wait_ready();
      @(negedge rclk);   // first read taken
      if (req_ready) flag_error("req_ready not low after first read");
      req = '{wr: 1'b0, way_sel: 2'b10, set: sb, word_en: 4'h0, wdata: '0};   // valid held
      @(negedge rclk);
      if (!req_ready) flag_error("req_ready not back high one cycle after accept");
      @(negedge rclk);   // second read taken
      req_valid = 1'b0;
      if (req_ready) flag_error("req_ready not low after second read");
      for (int c = 0; c < 5; c++) begin
         exp = (c < 2) ? model_get(0, sa) : (c < 4) ? model_get(1, sb) : '0;
         if (rsp_valid !== (c < 4)) flag_error($sformatf("rsp_valid wrong in cycle %0d", c));
         if (rd_chain_out !== exp) flag_error($sformatf("back-to-back line wrong, cycle %0d", c));
         @(negedge rclk);
      end
      finish_test("occupancy");
   endtask

   task automatic test_write_disable();
      logic [9:0] s;
      s = 10'($urandom());
      write_line(2'b01, s, 4'hf, rand_line());
      @(negedge rclk);   // base line committed before the disable goes up
      write_disable = 1'b1;
      write_line(2'b01, s, 4'hf, rand_line());   // model keeps old line
      @(negedge rclk);   // commit edge has sampled the disable
      write_disable = 1'b0;
      read_check(0, s, '0);
      finish_test("write disable");
   endtask

   task automatic test_read_bus();
      logic [9:0] s;
      for (int i = 0; i < 3; i++) begin
         s = 10'($urandom());
         write_line(2'b10, s, 4'hf, rand_line());
         read_check(1, s, rand_line());   // upstream bank traffic
      end
      finish_test("wired-or read bus");
   endtask

   task automatic test_fuse();
      logic exp_bit;
      for (int r = 0; r < NREG; r++) begin
         for (int b = NBIT - 1; b >= 0; b--) begin   // msb first
            fuse_cmd = '{wren: 1'b1, rden: 1'b0, rid: 3'(r), wdata: FUSE_PAT[r][b]};
            @(negedge rclk);
         end
         // unused id, write wins over read, nothing moves
         fuse_cmd = '{wren: 1'b1, rden: 1'b1, rid: (r % 2 == 0) ? 3'd6 : 3'd7, wdata: 1'b1};
         @(negedge rclk);
      end
      fuse_cmd = '{wren: 1'b0, rden: 1'b1, rid: 3'd0, wdata: 1'b0};
      for (int k = 0; k < NREG * NBIT + 6; k++) begin
         exp_bit = (k < NREG * NBIT) ? FUSE_PAT[NREG - 1 - k / NBIT][NBIT - 1 - k % NBIT] : 1'b0;
         if (fuse_out !== exp_bit) flag_error($sformatf("fuse_out bit %0d wrong", k));
         @(negedge rclk);
      end
      fuse_cmd = '0;
      finish_test("fuse chain");
   endtask

   //////////////////////////////////////////////////////////////////////
   // sequence and watchdog
   //////////////////////////////////////////////////////////////////////

   initial begin
      void'($urandom(32'h2ad3909a));
      errors = 0;
      test_errors = 0;
      tests_run = 0;
      tests_failed = 0;
      arst_l = 1'b0;
      req = '0;
      req_valid = 1'b0;
      write_disable = 1'b0;
      rd_chain_in = '0;
      fuse_cmd = '0;
      fuse_read_in = 1'b0;
      repeat (16) @(posedge rclk);
      @(negedge rclk);
      arst_l = 1'b1;
      if (!req_ready || rsp_valid || fuse_out) flag_error("bad bank state after reset");
      test_full_write();
      test_partial_write();
      test_occupancy();
      test_write_disable();
      test_read_bus();
      test_fuse();
      $display("tests run %0d, tests failed %0d, failed checks %0d",
               tests_run, tests_failed, errors);
      if (errors == 0) $display("RESULT: PASS");
      else $display("RESULT: FAIL");
      $finish;
   end

   initial begin
      #(NUM_TESTS * 200 * CYCLE_NS);
      $display("watchdog expired, tests did not finish in %0d cycles", NUM_TESTS * 200);
      $display("tests run %0d, tests failed %0d, failed checks %0d",
               tests_run, tests_failed, errors);
      $display("RESULT: FAIL");
      $finish;
   end

endmodule

// File: compile.f
+incdir+src
src/l2d_pkg.sv
src/l2d_req_stage.sv
src/l2d_array_stage.sv
src/l2d_rd_return.sv
src/l2d_fuse_chain.sv
src/l2d_bank.sv
testbench/tb_l2d_bank.sv

// File: run_sim.sh
#!/bin/sh
# verilator build of the l2 data bank testbench, then run and look for the pass line
verilator --binary --timing --assert -f compile.f --top-module tb_l2d_bank \
   -Mdir obj_dir -o sim_l2d_bank \
   && ./obj_dir/sim_l2d_bank | tee /dev/stderr | grep -qx "RESULT: PASS" \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }
